//--- src.f
+incdir+.
ex_mem_pkg.sv
alu.sv
csr_file.sv
ex_mem_register.sv
data_memory.sv
writeback_select.sv
ex_mem_slice.sv
tb_ex_mem_slice.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_ex_mem_slice
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
PASS_TEXT ?= Everything OK

SOURCES := $(shell grep -v '^+' $(FILELIST)) ex_mem_config.svh
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_ex_mem_slice.sv
`default_nettype none

`include "ex_mem_config.svh"

module tb_ex_mem_slice;

    localparam int WORD_BITS = $clog2(`DMEM_WORDS);
    localparam int IDX_BITS  = $clog2(`CSR_COUNT);

    logic                clk;
    logic                reset;
    logic                flush;
    logic [`XLEN-1:0]    pc_plus_4;
    logic [`XLEN-1:0]    rs1_data;
    logic [`XLEN-1:0]    rs2_data;
    logic [`XLEN-1:0]    imm;
    ex_mem_pkg::alu_op_t alu_op;
    logic                alu_src_imm;
    logic [2:0]          funct3;
    logic                memory_read;
    logic                memory_write;
    ex_mem_pkg::wb_sel_t wb_select;
    logic                register_write_enable;
    logic                csr_write_enable;
    logic                wb_enable;
    logic [`XLEN-1:0]    wb_data;

    logic [`XLEN-1:0]    model_mem [`DMEM_WORDS];
    logic [`XLEN-1:0]    model_csr [`CSR_COUNT];
    logic                csr_pending;       // csr write still in MEM
    logic [IDX_BITS-1:0] csr_pending_index;
    logic [`XLEN-1:0]    csr_pending_value;
    logic                exp_valid;
    logic                exp_en;
    logic [`XLEN-1:0]    exp_data;
    string               exp_name;
    int                  checks;
    int                  errors;
    int                  last_checks;
    int                  last_errors;
    int                  wait_cycles;

    ex_mem_slice dut (
        .clk                   (clk),
        .reset                 (reset),
        .flush                 (flush),
        .pc_plus_4             (pc_plus_4),
        .rs1_data              (rs1_data),
        .rs2_data              (rs2_data),
        .imm                   (imm),
        .alu_op                (alu_op),
        .alu_src_imm           (alu_src_imm),
        .funct3                (funct3),
        .memory_read           (memory_read),
        .memory_write          (memory_write),
        .wb_select             (wb_select),
        .register_write_enable (register_write_enable),
        .csr_write_enable      (csr_write_enable),
        .wb_enable             (wb_enable),
        .wb_data               (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // reset held over four rising edges
    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
    end

    function automatic logic [`XLEN-1:0] rnd(input int unsigned n);
        return $urandom % n;
    endfunction

    // aligned byte offset for an access of the given width
    function automatic logic [`XLEN-1:0] lane_offset(input logic [2:0] width);
        case (width[1:0])
            2'b00:   return rnd(4);
            2'b01:   return rnd(2) << 1;
            default: return '0;
        endcase
    endfunction

    function automatic logic [`XLEN-1:0] model_alu(input ex_mem_pkg::alu_op_t op,
                                                   input logic [`XLEN-1:0] a,
                                                   input logic [`XLEN-1:0] b,
                                                   input logic [`XLEN-1:0] csr);
        case (op)
            ex_mem_pkg::ADD:       return a + b;
            ex_mem_pkg::SUB:       return a - b;
            ex_mem_pkg::AND:       return a & b;
            ex_mem_pkg::OR:        return a | b;
            ex_mem_pkg::XOR:       return a ^ b;
            ex_mem_pkg::SLL:       return a << b[4:0];
            ex_mem_pkg::SRL:       return a >> b[4:0];
            ex_mem_pkg::SRA:       return $signed(a) >>> b[4:0];
            ex_mem_pkg::SLT:       return {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ex_mem_pkg::SLTU:      return {{(`XLEN-1){1'b0}}, a < b};
            ex_mem_pkg::CSR_WRITE: return a;
            ex_mem_pkg::CSR_SET:   return csr | a;
            ex_mem_pkg::CSR_CLEAR: return csr & ~a;
            default:               return '0;
        endcase
    endfunction

    function automatic logic [`XLEN-1:0] model_load(input logic [2:0] f3,
                                                    input logic [`XLEN-1:0] word,
                                                    input logic [1:0] off);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[8*off +: 8];
        h = off[1] ? word[31:16] : word[15:0];
        case (f3)
            3'b000:  return {{24{b[7]}}, b};
            3'b001:  return {{16{h[15]}}, h};
            3'b100:  return {24'b0, b};
            3'b101:  return {16'b0, h};
            default: return word;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [`XLEN-1:0] expected,
                               input logic [`XLEN-1:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic check_pending();
        if (exp_valid) begin
            check_value({exp_name, " wb_enable"}, {{(`XLEN-1){1'b0}}, exp_en},
                        {{(`XLEN-1){1'b0}}, wb_enable});
            check_value({exp_name, " wb_data"}, exp_data, wb_data);
            exp_valid = 1'b0;
        end
    endtask

    // drive one instruction, check the one before it, then model this one
    task automatic issue(input string name, input logic fl, input ex_mem_pkg::alu_op_t op,
                         input logic src_imm, input logic [2:0] f3, input logic wr,
                         input ex_mem_pkg::wb_sel_t wsel, input logic cwe,
                         input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b,
                         input logic [`XLEN-1:0] i);
        logic [`XLEN-1:0]     pc;
        logic [`XLEN-1:0]     csr_old;
        logic [`XLEN-1:0]     result;
        logic [IDX_BITS-1:0]  idx;
        logic [WORD_BITS-1:0] w;
        pc = $urandom;
        @(posedge clk);
        flush                 <= fl;
        pc_plus_4             <= pc;
        rs1_data              <= a;
        rs2_data              <= b;
        imm                   <= i;
        alu_op                <= op;
        alu_src_imm           <= src_imm;
        funct3                <= f3;
        memory_read           <= (wsel == ex_mem_pkg::WB_LOAD);
        memory_write          <= wr;
        wb_select             <= wsel;
        register_write_enable <= !wr; // stores have no rd
        csr_write_enable      <= cwe;
        @(negedge clk);
        check_pending();
        idx = i[IDX_BITS-1:0];
        csr_old = (csr_pending && csr_pending_index == idx) ? csr_pending_value
                                                             : model_csr[idx];
        result = model_alu(op, a, src_imm ? i : b, csr_old);
        if (csr_pending) begin
            model_csr[csr_pending_index] = csr_pending_value;
        end
        csr_pending       = !fl && cwe;
        csr_pending_index = idx;
        csr_pending_value = result;
        w = result[WORD_BITS+1:2];
        if (!fl && wr) begin
            case (f3)
                3'b000:  model_mem[w][8*result[1:0] +: 8] = b[7:0];
                3'b001:  model_mem[w][8*result[1:0] +: 16] = b[15:0];
                default: model_mem[w] = b;
            endcase
        end
        exp_valid = 1'b1;
        exp_name  = name;
        exp_en    = !fl && !wr;
        if (fl) begin
            exp_data = '0;
        end else begin
            case (wsel)
                ex_mem_pkg::WB_LOAD: exp_data = model_load(f3, model_mem[w], result[1:0]);
                ex_mem_pkg::WB_PC4:  exp_data = pc;
                ex_mem_pkg::WB_IMM:  exp_data = i;
                ex_mem_pkg::WB_CSR:  exp_data = csr_old;
                default:             exp_data = result;
            endcase
        end
    endtask

    task automatic end_test(input string name);
        issue(name, 1'b1, ex_mem_pkg::ADD, 1'b0, 3'b000, 1'b0, ex_mem_pkg::WB_ALU, 1'b0,
              '0, '0, '0);
        @(posedge clk);
        @(negedge clk);
        check_pending();
        $display("test %s: %0d checks, %0d errors", name, checks - last_checks,
                 errors - last_errors);
        last_checks = checks;
        last_errors = errors;
    endtask

    task automatic read_csr(input string name, input logic [`XLEN-1:0] index);
        issue(name, 1'b0, ex_mem_pkg::CSR_SET, 1'b0, 3'b000, 1'b0, ex_mem_pkg::WB_CSR, 1'b0,
              '0, $urandom, index); // set with zero leaves it unchanged
    endtask

    task automatic run_alu_ops();
        repeat (60) begin
            issue("alu_ops", 1'b0, ex_mem_pkg::alu_op_t'(4'(rnd(10))), 1'(rnd(2)), 3'b000,
                  1'b0, ex_mem_pkg::WB_ALU, 1'b0, $urandom, $urandom, $urandom);
        end
        end_test("alu_ops");
    endtask

    task automatic run_store_load();
        logic [`XLEN-1:0] base;
        logic [2:0]       width;
        repeat (20) begin
            base  = rnd(`DMEM_WORDS) << 2;
            width = 3'(rnd(3));
            issue("store_load", 1'b0, ex_mem_pkg::ADD, 1'b1, 3'b010, 1'b1, ex_mem_pkg::WB_ALU,
                  1'b0, base, $urandom, '0); // whole word first, no X bytes
            issue("store_load", 1'b0, ex_mem_pkg::ADD, 1'b1, width, 1'b1, ex_mem_pkg::WB_ALU,
                  1'b0, base, $urandom, lane_offset(width));
            for (int k = 0; k < 5; k++) begin
                width = 3'(k < 3 ? k : k + 1);
                issue("store_load", 1'b0, ex_mem_pkg::ADD, 1'b1, width, 1'b0,
                      ex_mem_pkg::WB_LOAD, 1'b0, base, $urandom, lane_offset(width));
            end
        end
        end_test("store_load");
    endtask

    task automatic run_csr_ops();
        repeat (40) begin
            issue("csr_ops", 1'b0, ex_mem_pkg::alu_op_t'(4'(10 + rnd(3))), 1'b0, 3'b000, 1'b0,
                  ex_mem_pkg::WB_CSR, 1'b1, $urandom, $urandom, $urandom);
        end
        for (int i = 0; i < `CSR_COUNT; i++) begin
            read_csr("csr_ops", i);
        end
        end_test("csr_ops");
    endtask

    task automatic run_other_sources();
        repeat (20) begin
            issue("pc4_imm", 1'b0, ex_mem_pkg::ADD, 1'b0, 3'b000, 1'b0,
                  rnd(2) == 0 ? ex_mem_pkg::WB_PC4 : ex_mem_pkg::WB_IMM, 1'b0,
                  $urandom, $urandom, $urandom);
        end
        end_test("pc4_imm");
    endtask

    task automatic run_flush();
        logic [`XLEN-1:0] base;
        logic [`XLEN-1:0] index;
        repeat (10) begin
            base  = rnd(`DMEM_WORDS) << 2;
            index = rnd(`CSR_COUNT);
            issue("flush", 1'b0, ex_mem_pkg::ADD, 1'b1, 3'b010, 1'b1, ex_mem_pkg::WB_ALU,
                  1'b0, base, $urandom, '0);
            issue("flush", 1'b1, ex_mem_pkg::ADD, 1'b1, 3'b010, 1'b1, ex_mem_pkg::WB_ALU,
                  1'b0, base, $urandom, '0);
            issue("flush", 1'b0, ex_mem_pkg::ADD, 1'b1, 3'b010, 1'b0, ex_mem_pkg::WB_LOAD,
                  1'b0, base, $urandom, '0);
            issue("flush", 1'b1, ex_mem_pkg::CSR_WRITE, 1'b0, 3'b000, 1'b0, ex_mem_pkg::WB_CSR,
                  1'b1, $urandom, $urandom, index);
            read_csr("flush", index);
            issue("flush", 1'b1, ex_mem_pkg::alu_op_t'(4'(rnd(10))), 1'b0, 3'b000, 1'b0,
                  ex_mem_pkg::WB_ALU, 1'b0, $urandom, $urandom, $urandom);
        end
        end_test("flush");
    endtask

    initial begin
        void'($urandom(32'h8b5a_2e2b));
        flush                 = 1'b0;
        pc_plus_4             = '0;
        rs1_data              = '0;
        rs2_data              = '0;
        imm                   = '0;
        alu_op                = ex_mem_pkg::ADD;
        alu_src_imm           = 1'b0;
        funct3                = 3'b000;
        memory_read           = 1'b0;
        memory_write          = 1'b0;
        wb_select             = ex_mem_pkg::WB_ALU;
        register_write_enable = 1'b0;
        csr_write_enable      = 1'b0;
        csr_pending           = 1'b0;
        exp_valid             = 1'b0;
        checks                = 0;
        errors                = 0;
        last_checks           = 0;
        last_errors           = 0;
        for (int i = 0; i < `CSR_COUNT; i++) begin
            model_csr[i] = '0;
        end
        wait_cycles = 0;
        while (reset !== 1'b0 && wait_cycles < 10) begin
            @(negedge clk);
            check_value("reset wb_enable", '0, {{(`XLEN-1){1'b0}}, wb_enable});
            wait_cycles++;
        end
        if (reset !== 1'b0) begin
            $display("timeout: reset was never released");
            $display("Something failed");
            $finish;
        end
        for (int i = 0; i < `CSR_COUNT; i++) begin
            read_csr("reset", i); // all zero after reset
        end
        end_test("reset");
        run_alu_ops();
        run_store_load();
        run_csr_ops();
        run_other_sources();
        run_flush();
        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- ex_mem_slice.sv
`default_nettype none

`include "ex_mem_config.svh"

module ex_mem_slice (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  flush,
    input  logic [`XLEN-1:0]      pc_plus_4,
    input  logic [`XLEN-1:0]      rs1_data,
    input  logic [`XLEN-1:0]      rs2_data,
    input  logic [`XLEN-1:0]      imm,
    input  ex_mem_pkg::alu_op_t   alu_op,
    input  logic                  alu_src_imm,
    input  logic [2:0]            funct3,
    input  logic                  memory_read,
    input  logic                  memory_write,
    input  ex_mem_pkg::wb_sel_t   wb_select,
    input  logic                  register_write_enable,
    input  logic                  csr_write_enable,
    output logic                  wb_enable,
    output logic [`XLEN-1:0]      wb_data
);

    logic [`XLEN-1:0]    alu_result;
    logic [`XLEN-1:0]    csr_read_data;
    logic [`XLEN-1:0]    mem_pc_plus_4;
    logic                mem_memory_write;
    ex_mem_pkg::wb_sel_t mem_wb_select;
    logic                mem_csr_write_enable;
    logic [2:0]          mem_funct3;
    logic [`XLEN-1:0]    mem_read_data2;
    logic [`XLEN-1:0]    mem_imm;
    logic [`XLEN-1:0]    mem_csr_read_data;
    logic [`XLEN-1:0]    mem_alu_result;
    logic [`XLEN-1:0]    load_word;

    alu u_alu (
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .imm         (imm),
        .csr_value   (csr_read_data),
        .alu_src_imm (alu_src_imm),
        .alu_op      (alu_op),
        .result      (alu_result)
    );

    // EX read, MEM write of the new value
    csr_file u_csr_file (
        .clk          (clk),
        .reset        (reset),
        .read_index   (imm),
        .write_enable (mem_csr_write_enable),
        .write_index  (mem_imm),
        .write_data   (mem_alu_result),
        .read_data    (csr_read_data)
    );

    ex_mem_register u_ex_mem_register (
        .clk                                 (clk),
        .reset                               (reset),
        .flush                               (flush),
        .ex_pc_plus_4                        (pc_plus_4),
        .ex_memory_read                      (memory_read),
        .ex_memory_write                     (memory_write),
        .ex_register_file_write_data_select  (wb_select),
        .ex_register_write_enable            (register_write_enable),
        .ex_csr_write_enable                 (csr_write_enable),
        .ex_funct3                           (funct3),
        .ex_read_data2                       (rs2_data),
        .ex_imm                              (imm),
        .ex_csr_read_data                    (csr_read_data),
        .ex_alu_result                       (alu_result),
        .mem_pc_plus_4                       (mem_pc_plus_4),
        .mem_memory_read                     (),  // memory reads are combinational
        .mem_memory_write                    (mem_memory_write),
        .mem_register_file_write_data_select (mem_wb_select),
        .mem_register_write_enable           (wb_enable),
        .mem_csr_write_enable                (mem_csr_write_enable),
        .mem_funct3                          (mem_funct3),
        .mem_read_data2                      (mem_read_data2),
        .mem_imm                             (mem_imm),
        .mem_csr_read_data                   (mem_csr_read_data),
        .mem_alu_result                      (mem_alu_result)
    );

    data_memory u_data_memory (
        .clk          (clk),
        .write_enable (mem_memory_write),
        .address      (mem_alu_result),
        .width        (mem_funct3),
        .write_data   (mem_read_data2),
        .read_word    (load_word)
    );

    writeback_select u_writeback_select (
        .wb_select     (mem_wb_select),
        .funct3        (mem_funct3),
        .address_low   (mem_alu_result[1:0]),
        .load_word     (load_word),
        .alu_result    (mem_alu_result),
        .pc_plus_4     (mem_pc_plus_4),
        .imm           (mem_imm),
        .csr_read_data (mem_csr_read_data),
        .wb_data       (wb_data)
    );

endmodule

`default_nettype wire

//--- writeback_select.sv
`default_nettype none

`include "ex_mem_config.svh"

module writeback_select (
    input  ex_mem_pkg::wb_sel_t   wb_select,
    input  logic [2:0]            funct3,
    input  logic [1:0]            address_low,
    input  logic [`XLEN-1:0]      load_word,
    input  logic [`XLEN-1:0]      alu_result,
    input  logic [`XLEN-1:0]      pc_plus_4,
    input  logic [`XLEN-1:0]      imm,
    input  logic [`XLEN-1:0]      csr_read_data,
    output logic [`XLEN-1:0]      wb_data
);

    logic [`XLEN-1:0] shifted;
    logic [`XLEN-1:0] load_data;

    assign shifted = load_word >> {address_low, 3'b000}; // addressed lane to bit 0

    always_comb begin
        case (ex_mem_pkg::mem_width_t'(funct3))
            ex_mem_pkg::BYTE:   load_data = {{(`XLEN-8){shifted[7]}}, shifted[7:0]};
            ex_mem_pkg::HALF:   load_data = {{(`XLEN-16){shifted[15]}}, shifted[15:0]};
            ex_mem_pkg::BYTE_U: load_data = {{(`XLEN-8){1'b0}}, shifted[7:0]};
            ex_mem_pkg::HALF_U: load_data = {{(`XLEN-16){1'b0}}, shifted[15:0]};
            default:            load_data = load_word;
        endcase
    end

    always_comb begin
        case (wb_select)
            ex_mem_pkg::WB_ALU:  wb_data = alu_result;
            ex_mem_pkg::WB_LOAD: wb_data = load_data;
            ex_mem_pkg::WB_PC4:  wb_data = pc_plus_4;
            ex_mem_pkg::WB_IMM:  wb_data = imm;
            ex_mem_pkg::WB_CSR:  wb_data = csr_read_data; // old value goes to rd
            default:             wb_data = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- data_memory.sv
`default_nettype none

`include "ex_mem_config.svh"

module data_memory (
    input  logic             clk,
    input  logic             write_enable,
    input  logic [`XLEN-1:0] address,    // byte address
    input  logic [2:0]       width,      // funct3
    input  logic [`XLEN-1:0] write_data,
    output logic [`XLEN-1:0] read_word
);

    localparam int ADDR_W = $clog2(`DMEM_WORDS);

    logic [`XLEN-1:0]  mem [`DMEM_WORDS];
    logic [ADDR_W-1:0] word_index;
    logic [1:0]        byte_offset;
    logic [3:0]        lane_enable;
    logic [`XLEN-1:0]  lane_data;

    assign word_index  = address[ADDR_W+1:2]; // upper bits ignored
    assign byte_offset = address[1:0];
    assign lane_data   = write_data << {byte_offset, 3'b000};

    always_comb begin
        case (ex_mem_pkg::mem_width_t'(width))
            ex_mem_pkg::BYTE,
            ex_mem_pkg::BYTE_U: lane_enable = 4'b0001 << byte_offset;
            ex_mem_pkg::HALF,
            ex_mem_pkg::HALF_U: lane_enable = 4'b0011 << byte_offset;
            ex_mem_pkg::WORD:   lane_enable = 4'b1111;
            default:            lane_enable = 4'b0000;
        endcase
    end

    always_ff @(posedge clk) begin
        if (write_enable) begin
            for (int i = 0; i < 4; i++) begin
                if (lane_enable[i]) begin
                    mem[word_index][8*i +: 8] <= lane_data[8*i +: 8];
                end
            end
        end
    end

    assign read_word = mem[word_index]; // raw word, aligned later

endmodule

`default_nettype wire

//--- ex_mem_register.sv
`default_nettype none

`include "ex_mem_config.svh"

module ex_mem_register (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  flush,

    input  logic [`XLEN-1:0]      ex_pc_plus_4,
    input  logic                  ex_memory_read,
    input  logic                  ex_memory_write,
    input  ex_mem_pkg::wb_sel_t   ex_register_file_write_data_select,
    input  logic                  ex_register_write_enable,
    input  logic                  ex_csr_write_enable,
    input  logic [2:0]            ex_funct3,
    input  logic [`XLEN-1:0]      ex_read_data2, // store data
    input  logic [`XLEN-1:0]      ex_imm,
    input  logic [`XLEN-1:0]      ex_csr_read_data,
    input  logic [`XLEN-1:0]      ex_alu_result,

    output logic [`XLEN-1:0]      mem_pc_plus_4,
    output logic                  mem_memory_read,
    output logic                  mem_memory_write,
    output ex_mem_pkg::wb_sel_t   mem_register_file_write_data_select,
    output logic                  mem_register_write_enable,
    output logic                  mem_csr_write_enable,
    output logic [2:0]            mem_funct3,
    output logic [`XLEN-1:0]      mem_read_data2,
    output logic [`XLEN-1:0]      mem_imm,
    output logic [`XLEN-1:0]      mem_csr_read_data,
    output logic [`XLEN-1:0]      mem_alu_result
);

    always_ff @(posedge clk or posedge reset) begin
        if (reset || flush) begin // flush only acts on the edge, reset is async
            mem_pc_plus_4                       <= '0;
            mem_memory_read                     <= 1'b0;
            mem_memory_write                    <= 1'b0;
            mem_register_file_write_data_select <= ex_mem_pkg::WB_ALU;
            mem_register_write_enable           <= 1'b0;
            mem_csr_write_enable                <= 1'b0;
            mem_funct3                          <= 3'b000;
            mem_read_data2                      <= '0;
            mem_imm                             <= '0;
            mem_csr_read_data                   <= '0;
            mem_alu_result                      <= '0;
        end else begin
            mem_pc_plus_4                       <= ex_pc_plus_4;
            mem_memory_read                     <= ex_memory_read;
            mem_memory_write                    <= ex_memory_write;
            mem_register_file_write_data_select <= ex_register_file_write_data_select;
            mem_register_write_enable           <= ex_register_write_enable;
            mem_csr_write_enable                <= ex_csr_write_enable;
            mem_funct3                          <= ex_funct3;
            mem_read_data2                      <= ex_read_data2;
            mem_imm                             <= ex_imm;
            mem_csr_read_data                   <= ex_csr_read_data;
            mem_alu_result                      <= ex_alu_result;
        end
    end

endmodule

`default_nettype wire

//--- csr_file.sv
`default_nettype none

`include "ex_mem_config.svh"

module csr_file (
    input  logic             clk,
    input  logic             reset,
    input  logic [`XLEN-1:0] read_index,  // EX side, from imm
    input  logic             write_enable,
    input  logic [`XLEN-1:0] write_index, // MEM side, registered imm
    input  logic [`XLEN-1:0] write_data,
    output logic [`XLEN-1:0] read_data
);

    localparam int IDX_W = $clog2(`CSR_COUNT);

    logic [`XLEN-1:0] csr_regs [`CSR_COUNT];
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;

    assign rd_idx = read_index[IDX_W-1:0];
    assign wr_idx = write_index[IDX_W-1:0];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `CSR_COUNT; i++) begin
                csr_regs[i] <= '0;
            end
        end else if (write_enable) begin
            csr_regs[wr_idx] <= write_data;
        end
    end

    // a write still in MEM wins over the stored value
    always_comb begin
        if (write_enable && (wr_idx == rd_idx)) begin
            read_data = write_data;
        end else begin
            read_data = csr_regs[rd_idx];
        end
    end

endmodule

`default_nettype wire

//--- alu.sv
`default_nettype none

`include "ex_mem_config.svh"

module alu (
    input  logic [`XLEN-1:0]      rs1_data,
    input  logic [`XLEN-1:0]      rs2_data,
    input  logic [`XLEN-1:0]      imm,
    input  logic [`XLEN-1:0]      csr_value,
    input  logic                  alu_src_imm,
    input  ex_mem_pkg::alu_op_t   alu_op,
    output logic [`XLEN-1:0]      result
);

    logic [`XLEN-1:0] operand_b;
    logic [4:0]       shamt;
    logic             lt_signed;
    logic             lt_unsigned;

    assign operand_b   = alu_src_imm ? imm : rs2_data;
    assign shamt       = operand_b[4:0];
    assign lt_signed   = $signed(rs1_data) < $signed(operand_b);
    assign lt_unsigned = rs1_data < operand_b;

    always_comb begin
        case (alu_op)
            ex_mem_pkg::ADD:       result = rs1_data + operand_b;
            ex_mem_pkg::SUB:       result = rs1_data - operand_b;
            ex_mem_pkg::AND:       result = rs1_data & operand_b;
            ex_mem_pkg::OR:        result = rs1_data | operand_b;
            ex_mem_pkg::XOR:       result = rs1_data ^ operand_b;
            ex_mem_pkg::SLL:       result = rs1_data << shamt;
            ex_mem_pkg::SRL:       result = rs1_data >> shamt;
            ex_mem_pkg::SRA:       result = $signed(rs1_data) >>> shamt;
            ex_mem_pkg::SLT:       result = {{(`XLEN-1){1'b0}}, lt_signed};
            ex_mem_pkg::SLTU:      result = {{(`XLEN-1){1'b0}}, lt_unsigned};
            // new csr value, written back in MEM
            ex_mem_pkg::CSR_WRITE: result = rs1_data;
            ex_mem_pkg::CSR_SET:   result = csr_value | rs1_data;
            ex_mem_pkg::CSR_CLEAR: result = csr_value & ~rs1_data;
            default:               result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- ex_mem_pkg.sv
`default_nettype none

package ex_mem_pkg;

    typedef enum logic [3:0] {
        ADD       = 4'd0,
        SUB       = 4'd1,
        AND       = 4'd2,
        OR        = 4'd3,
        XOR       = 4'd4,
        SLL       = 4'd5,
        SRL       = 4'd6,
        SRA       = 4'd7,
        SLT       = 4'd8,
        SLTU      = 4'd9,
        CSR_WRITE = 4'd10, // passes rs1
        CSR_SET   = 4'd11, // csr | rs1
        CSR_CLEAR = 4'd12  // csr & ~rs1
    } alu_op_t;

    typedef enum logic [2:0] {
        WB_ALU  = 3'd0,
        WB_LOAD = 3'd1,
        WB_PC4  = 3'd2,
        WB_IMM  = 3'd3,
        WB_CSR  = 3'd4
    } wb_sel_t;

    // same encoding as the RISC-V load/store funct3
    typedef enum logic [2:0] {
        BYTE   = 3'b000,
        HALF   = 3'b001,
        WORD   = 3'b010,
        BYTE_U = 3'b100,
        HALF_U = 3'b101
    } mem_width_t;

endpackage

`default_nettype wire

//--- ex_mem_config.svh
`ifndef EX_MEM_CONFIG_SVH
`define EX_MEM_CONFIG_SVH

// data path width, the design assumes 32
`define XLEN 32

// data memory size in 32-bit words, power of two
`define DMEM_WORDS 256

// number of CSRs, power of two
`define CSR_COUNT 4

`endif
